/* design/opq_cfg.svh */
`ifndef OPQ_CFG_SVH
`define OPQ_CFG_SVH

////////////////////////////////////////
// Datapath
////////////////////////////////////////

// Width of one register file word
`define OPQ_ELEN 64

////////////////////////////////////////
// Buffering
////////////////////////////////////////

// Entries in each buffer, also the credit limit
`define OPQ_DEPTH 2

// Width of the vl field and of the element counter
`define OPQ_VL_W 16

`endif

/* design/opq_pkg.sv */
`default_nettype none

`include "opq_cfg.svh"

package opq_pkg;

  // Source element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } opq_eew_e;

  // Conversion applied to the head word
  typedef enum logic [2:0] {
    CONV_NONE    = 3'd0,
    CONV_SEXT2   = 3'd1,
    CONV_ZEXT2   = 3'd2,
    CONV_SEXT4   = 3'd3,
    CONV_ZEXT4   = 3'd4,
    CONV_FPWIDE2 = 3'd5
  } opq_conv_e;

  // Command from the operand requester
  // target_fu is 0 for the slide unit, 1 for the address generator
  typedef struct packed {
    opq_conv_e             conv;
    opq_eew_e              eew;
    logic [`OPQ_VL_W-1:0]  vl;
    logic                  target_fu;
  } opq_cmd_t;

  // IEEE half precision fields
  typedef struct packed {
    logic       sign;
    logic [4:0] exponent;
    logic [9:0] mantissa;
  } opq_fp16_t;

  // One 16-bit slice of a word, integer or FP16
  typedef union packed {
    logic [15:0] raw;
    opq_fp16_t   fp;
  } opq_half_u;

endpackage

`default_nettype wire

/* design/opq_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module opq_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter int unsigned WIDTH = 64
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [WIDTH-1:0] data_i,
  input  logic             push_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push, do_pop;

  // A push into a full buffer is dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Usage moves only when exactly one side is active
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/opq_credit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opq_cfg.svh"

module opq_credit_counter (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic issued_i,
  input  logic consumed_i,
  output logic ready_o
);

  localparam int unsigned CNT_W = $clog2(`OPQ_DEPTH + 1);

  // Words promised by the register file and not yet popped
  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      if (issued_i && !consumed_i) begin
        count_q <= count_q + 1'b1;
      end else if (consumed_i && !issued_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Room left for one more word in the operand buffer
  assign ready_o = (count_q < CNT_W'(`OPQ_DEPTH));

endmodule

`default_nettype wire

/* design/opq_convert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opq_cfg.svh"

module opq_convert import opq_pkg::*; (
  input  logic [`OPQ_ELEN-1:0] word_i,
  input  opq_conv_e            conv_i,
  input  opq_eew_e             eew_i,
  input  logic [2:0]           select_i,
  output logic [`OPQ_ELEN-1:0] word_o
);

  // FP32 bias minus FP16 bias
  localparam logic [7:0] FP_REBIAS = 8'd112;

  logic sign_ext;

  assign sign_ext = (conv_i == CONV_SEXT2) || (conv_i == CONV_SEXT4);

  ////////////////////////////////////////
  // Widening
  ////////////////////////////////////////

  // Output group e takes source element e counted from byte select_i,
  // so consecutive outputs walk through the word from the low end
  always_comb begin
    opq_half_u   half;
    logic [7:0]  byte_el;
    logic [31:0] word_el;
    logic [7:0]  exp_wide;

    word_o   = word_i;
    half     = '0;
    byte_el  = '0;
    word_el  = '0;
    exp_wide = '0;

    case (conv_i)
      CONV_SEXT2, CONV_ZEXT2: begin
        case (eew_i)
          EW8: begin
            for (int e = 0; e < 4; e++) begin
              byte_el = word_i[8*select_i + 8*e +: 8];
              word_o[16*e +: 16] = {{8{sign_ext & byte_el[7]}}, byte_el};
            end
          end
          EW16: begin
            for (int e = 0; e < 2; e++) begin
              half.raw = word_i[8*select_i + 16*e +: 16];
              word_o[32*e +: 32] = {{16{sign_ext & half.raw[15]}}, half.raw};
            end
          end
          EW32: begin
            word_el = word_i[8*select_i +: 32];
            word_o  = {{32{sign_ext & word_el[31]}}, word_el};
          end
          default: ;
        endcase
      end

      CONV_SEXT4, CONV_ZEXT4: begin
        case (eew_i)
          EW8: begin
            for (int e = 0; e < 2; e++) begin
              byte_el = word_i[8*select_i + 8*e +: 8];
              word_o[32*e +: 32] = {{24{sign_ext & byte_el[7]}}, byte_el};
            end
          end
          EW16: begin
            half.raw = word_i[8*select_i +: 16];
            word_o   = {{48{sign_ext & half.raw[15]}}, half.raw};
          end
          default: ;
        endcase
      end

      CONV_FPWIDE2: begin
        // Only the exponent is rebiased, special values are not handled
        if (eew_i == EW16) begin
          for (int e = 0; e < 2; e++) begin
            half.raw = word_i[8*select_i + 16*e +: 16];
            exp_wide = {3'b000, half.fp.exponent} + FP_REBIAS;
            word_o[32*e +: 32] = {half.fp.sign, exp_wide, half.fp.mantissa, 13'b0};
          end
        end
      end

      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* design/opq_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opq_cfg.svh"

module opq_sequencer import opq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  opq_cmd_t   cmd_i,
  input  logic       cmd_empty_i,
  input  logic       word_empty_i,
  input  logic       out_ready_i,
  output logic       out_valid_o,
  output logic [2:0] select_o,
  output logic       word_pop_o,
  output logic       cmd_pop_o
);

  logic [2:0]           select_q, select_next;
  logic [`OPQ_VL_W-1:0] cnt_q;
  logic [`OPQ_VL_W:0]   cnt_next;
  logic [3:0]           elem_cnt;
  logic [2:0]           sel_step;
  logic                 fire;
  logic                 done;

  // Elements per output word and byte advance of select
  // Unsupported pairs behave as a plain pass-through
  always_comb begin
    elem_cnt = 4'd8 >> cmd_i.eew;
    sel_step = 3'd0;
    case (cmd_i.conv)
      CONV_SEXT2, CONV_ZEXT2: begin
        if (cmd_i.eew != EW64) begin
          elem_cnt = 4'd4 >> cmd_i.eew;
          sel_step = 3'd4;
        end
      end
      CONV_SEXT4, CONV_ZEXT4: begin
        if (cmd_i.eew == EW8 || cmd_i.eew == EW16) begin
          elem_cnt = 4'd2 >> cmd_i.eew;
          sel_step = 3'd2;
        end
      end
      CONV_FPWIDE2: begin
        if (cmd_i.eew == EW16) begin
          elem_cnt = 4'd2;
          sel_step = 3'd4;
        end
      end
      default: ;
    endcase
  end

  assign out_valid_o = !cmd_empty_i && !word_empty_i;
  assign fire        = out_valid_o && out_ready_i;

  assign select_next = select_q + sel_step;
  assign cnt_next    = {1'b0, cnt_q} + (`OPQ_VL_W + 1)'(elem_cnt);
  assign done        = fire && (cnt_next >= {1'b0, cmd_i.vl});

  // Word is used up once select wraps, or at once when nothing is widened
  assign word_pop_o = done || (fire && (sel_step == 3'd0 || select_next == 3'd0));
  assign cmd_pop_o  = done;
  assign select_o   = select_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      select_q <= '0;
      cnt_q    <= '0;
    end else if (fire) begin
      if (done) begin
        // Next command starts from the low end of a fresh word
        select_q <= '0;
        cnt_q    <= '0;
      end else begin
        select_q <= select_next;
        cnt_q    <= cnt_next[`OPQ_VL_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* design/operand_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opq_cfg.svh"

module operand_queue import opq_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Command side
  input  opq_cmd_t             cmd_i,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  // Register file side
  input  logic [`OPQ_ELEN-1:0] operand_i,
  input  logic                 operand_valid_i,
  input  logic                 operand_issued_i,
  output logic                 operand_ready_o,
  // Functional unit side
  output logic [`OPQ_ELEN-1:0] operand_o,
  output logic                 target_fu_o,
  output logic                 operand_valid_o,
  input  logic                 operand_ready_i
);

  opq_cmd_t             cmd_head;
  logic                 cmd_empty, cmd_full, cmd_pop;
  logic [`OPQ_ELEN-1:0] word_head;
  logic                 word_empty, word_pop;
  logic [2:0]           select;

  ////////////////////////////////////////
  // Buffers
  ////////////////////////////////////////

  opq_fifo #(
    .DEPTH (`OPQ_DEPTH),
    .WIDTH ($bits(opq_cmd_t))
  ) i_cmd_buffer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (cmd_i),
    .push_i  (cmd_valid_i),
    .pop_i   (cmd_pop),
    .data_o  (cmd_head),
    .empty_o (cmd_empty),
    .full_o  (cmd_full)
  );

  assign cmd_ready_o = !cmd_full;

  // Never overflows, the credit counter holds back the issue side
  opq_fifo #(
    .DEPTH (`OPQ_DEPTH),
    .WIDTH (`OPQ_ELEN)
  ) i_word_buffer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (operand_i),
    .push_i  (operand_valid_i),
    .pop_i   (word_pop),
    .data_o  (word_head),
    .empty_o (word_empty),
    .full_o  ()
  );

  opq_credit_counter i_credit (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issued_i   (operand_issued_i),
    .consumed_i (word_pop),
    .ready_o    (operand_ready_o)
  );

  ////////////////////////////////////////
  // Conversion and output
  ////////////////////////////////////////

  opq_convert i_convert (
    .word_i   (word_head),
    .conv_i   (cmd_head.conv),
    .eew_i    (cmd_head.eew),
    .select_i (select),
    .word_o   (operand_o)
  );

  opq_sequencer i_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd_head),
    .cmd_empty_i  (cmd_empty),
    .word_empty_i (word_empty),
    .out_ready_i  (operand_ready_i),
    .out_valid_o  (operand_valid_o),
    .select_o     (select),
    .word_pop_o   (word_pop),
    .cmd_pop_o    (cmd_pop)
  );

  assign target_fu_o = cmd_head.target_fu;

endmodule

`default_nettype wire

/* bench/operand_queue_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opq_cfg.svh"

module operand_queue_sva (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 cmd_ready_o,
  input logic                 operand_issued_i,
  input logic                 operand_ready_o,
  input logic [`OPQ_ELEN-1:0] operand_o,
  input logic                 target_fu_o,
  input logic                 operand_valid_o,
  input logic                 operand_ready_i
);

  // A stalled output keeps its word and its target
  property hold_while_stalled;
    @(posedge clk_i) disable iff (!rst_ni)
      (operand_valid_o && !operand_ready_i) |=>
        (operand_valid_o && $stable(operand_o) && $stable(target_fu_o));
  endproperty

  // Nothing queued and room on both input sides
  property idle_after_reset;
    @(posedge clk_i)
      $rose(rst_ni) |-> (!operand_valid_o && cmd_ready_o && operand_ready_o);
  endproperty

  // Register file promises a word only with a free credit
  property issue_needs_credit;
    @(posedge clk_i) disable iff (!rst_ni)
      operand_issued_i |-> operand_ready_o;
  endproperty

  a_hold_while_stalled: assert property (hold_while_stalled)
    else $error("operand output changed while stalled");

  a_idle_after_reset: assert property (idle_after_reset)
    else $error("queue not idle after reset release");

  a_issue_needs_credit: assert property (issue_needs_credit)
    else $error("operand issued without a free credit");

endmodule

bind operand_queue operand_queue_sva i_sva (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .cmd_ready_o      (cmd_ready_o),
  .operand_issued_i (operand_issued_i),
  .operand_ready_o  (operand_ready_o),
  .operand_o        (operand_o),
  .target_fu_o      (target_fu_o),
  .operand_valid_o  (operand_valid_o),
  .operand_ready_i  (operand_ready_i)
);

`default_nettype wire

/* bench/operand_queue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "opq_cfg.svh"

module operand_queue_tb import opq_pkg::*; ();

  localparam int TIMEOUT = 2000;
  localparam int ELEN = `OPQ_ELEN;
  localparam int VL_W = `OPQ_VL_W;
  localparam int READY_ALWAYS = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_HOLD = 2;

  logic                 clk = 1'b0;
  logic                 rst_n;
  opq_cmd_t             cmd;
  logic                 cmd_valid, cmd_ready;
  logic [`OPQ_ELEN-1:0] operand;
  logic                 operand_valid, operand_issued, operand_ready;
  logic [`OPQ_ELEN-1:0] out_word;
  logic                 out_fu, out_valid, out_ready;

  // Pending stimulus and expected {target_fu, word} in output order
  opq_cmd_t             cmd_plan_q [$];
  logic [`OPQ_ELEN-1:0] word_plan_q [$];
  logic [`OPQ_ELEN:0]   exp_q [$];

  integer       seed;
  logic [255:0] ready_pattern;
  int           ready_mode;
  int           errors, timeouts, tests_run, tests_failed;
  int           outputs_checked, test_start_errors;

  always #2 clk = ~clk;

  operand_queue i_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .cmd_i            (cmd),
    .cmd_valid_i      (cmd_valid),
    .cmd_ready_o      (cmd_ready),
    .operand_i        (operand),
    .operand_valid_i  (operand_valid),
    .operand_issued_i (operand_issued),
    .operand_ready_o  (operand_ready),
    .operand_o        (out_word),
    .target_fu_o      (out_fu),
    .operand_valid_o  (out_valid),
    .operand_ready_i  (out_ready)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [63:0] low_bits(int n);
    return (64'd1 << n) - 64'd1;
  endfunction

  function automatic int parts_per_word(opq_conv_e conv);
    if (conv == CONV_NONE) return 1;
    if (conv == CONV_SEXT4 || conv == CONV_ZEXT4) return 4;
    return 2;
  endfunction

  function automatic int elems_per_output(opq_conv_e conv, opq_eew_e eew);
    return ELEN / ((8 << int'(eew)) * parts_per_word(conv));
  endfunction

  // Output part p of a word carries the source elements p*n to p*n+n-1, widened
  function automatic logic [63:0] widen_word(logic [63:0] word, opq_conv_e conv,
                                             opq_eew_e eew, int part);
    int          src_bits;
    int          dst_bits;
    int          per_out;
    logic [63:0] elem;
    logic [63:0] result;
    logic [7:0]  exp8;
    if (conv == CONV_NONE) return word;
    src_bits = 8 << int'(eew);
    dst_bits = src_bits * parts_per_word(conv);
    per_out  = ELEN / dst_bits;
    result   = '0;
    for (int j = 0; j < per_out; j++) begin
      elem = (word >> ((part * per_out + j) * src_bits)) & low_bits(src_bits);
      if (conv == CONV_FPWIDE2) begin
        // Rebias 15 to 127
        exp8 = 8'(elem[14:10]) + 8'd112;
        elem = {32'd0, elem[15], exp8, elem[9:0], 13'd0};
      end else if ((conv == CONV_SEXT2 || conv == CONV_SEXT4) && elem[src_bits-1]) begin
        elem = elem | ~low_bits(src_bits);
      end
      result = result | ((elem & low_bits(dst_bits)) << (j * dst_bits));
    end
    return result;
  endfunction

  function automatic logic [63:0] random_word(opq_conv_e conv);
    logic [63:0] w;
    logic [31:0] r;
    logic [4:0]  exp5;
    for (int h = 0; h < 4; h++) begin
      r = $random(seed);
      // Normal FP16 values only, exponent 1 to 30
      exp5 = (r[20:16] % 5'd30) + 5'd1;
      w[16*h +: 16] = (conv == CONV_FPWIDE2) ? {r[15], exp5, r[9:0]} : r[15:0];
    end
    return w;
  endfunction

  // Queue one command with just enough words and its expected outputs
  task automatic plan_command(opq_conv_e conv, opq_eew_e eew, int vl, logic fu);
    opq_cmd_t    c;
    logic [63:0] w;
    int          count;
    int          part;
    c.conv      = conv;
    c.eew       = eew;
    c.vl        = VL_W'(vl);
    c.target_fu = fu;
    cmd_plan_q.push_back(c);
    count = 0;
    part  = 0;
    w = random_word(conv);
    word_plan_q.push_back(w);
    while (count < vl) begin
      exp_q.push_back({fu, widen_word(w, conv, eew, part)});
      count += elems_per_output(conv, eew);
      part++;
      if (count < vl && part == parts_per_word(conv)) begin
        part = 0;
        w = random_word(conv);
        word_plan_q.push_back(w);
      end
    end
  endtask

  ////////////////////////////////////////
  // Drivers and monitor
  ////////////////////////////////////////

  task automatic finish_run();
    $display("tests %0d, failed %0d, outputs checked %0d, errors %0d, timeouts %0d",
             tests_run, tests_failed, outputs_checked, errors, timeouts);
    if (errors == 0 && timeouts == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic report_timeout(string what);
    timeouts++;
    $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
  endtask

  task automatic feed_commands();
    int cycles;
    while (cmd_plan_q.size() > 0) begin
      cmd       <= cmd_plan_q.pop_front();
      cmd_valid <= 1'b1;
      cycles = 0;
      @(posedge clk);
      while (!cmd_ready && cycles < TIMEOUT) begin
        @(posedge clk);
        cycles++;
      end
      if (!cmd_ready) begin
        report_timeout("the command port to accept");
        break;
      end
    end
    cmd_valid <= 1'b0;
  endtask

  // Issue pulse first, the word itself one cycle later
  task automatic send_word(logic [63:0] data);
    int cycles;
    cycles = 0;
    while (!operand_ready && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!operand_ready) begin
      report_timeout("a free operand credit");
      return;
    end
    operand_issued <= 1'b1;
    @(posedge clk);
    operand_issued <= 1'b0;
    operand        <= data;
    operand_valid  <= 1'b1;
    @(posedge clk);
    operand_valid  <= 1'b0;
  endtask

  task automatic feed_words();
    while (word_plan_q.size() > 0) begin
      send_word(word_plan_q.pop_front());
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_q.size() > 0 && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() > 0) report_timeout("all expected outputs");
  endtask

  task automatic run_plan();
    fork
      feed_commands();
      feed_words();
    join
    wait_drained();
  endtask

  task automatic drive_out_ready();
    logic [7:0] idx;
    idx = '0;
    forever begin
      @(posedge clk);
      case (ready_mode)
        READY_ALWAYS: out_ready <= 1'b1;
        READY_RANDOM: out_ready <= ready_pattern[idx];
        default:      out_ready <= 1'b0;
      endcase
      idx = idx + 8'd1;
    end
  endtask

  task automatic check_outputs();
    logic [`OPQ_ELEN:0] expected;
    forever begin
      @(posedge clk);
      if (rst_n && out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("ERROR %0t: unexpected output 0x%016h", $time, out_word);
          errors++;
        end else begin
          expected = exp_q.pop_front();
          outputs_checked++;
          assert (out_word == expected[63:0] && out_fu == expected[64]) else begin
            $display("ERROR %0t: output 0x%016h fu %0b, expected 0x%016h fu %0b",
                     $time, out_word, out_fu, expected[63:0], expected[64]);
            errors++;
          end
        end
      end
    end
  endtask

  task automatic end_test(string name);
    int new_errors;
    new_errors = errors - test_start_errors;
    tests_run++;
    if (new_errors == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, new_errors);
    end
    test_start_errors = errors;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int cycles;
    seed = 32'h9163;
    rst_n = 1'b0;
    cmd = '0;
    cmd_valid = 1'b0;
    operand = '0;
    operand_valid = 1'b0;
    operand_issued = 1'b0;
    out_ready = 1'b1;
    ready_mode = READY_ALWAYS;
    errors = 0;
    timeouts = 0;
    tests_run = 0;
    tests_failed = 0;
    outputs_checked = 0;
    test_start_errors = 0;
    for (int i = 0; i < 8; i++) begin
      ready_pattern[32*i +: 32] = $random(seed);
    end
    fork
      check_outputs();
      drive_out_ready();
    join_none
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    plan_command(CONV_NONE, EW32, 6, 1'b1);
    run_plan();
    end_test("plain pass-through");

    plan_command(CONV_SEXT2, EW8, 16, 1'b0);
    plan_command(CONV_ZEXT2, EW8, 8, 1'b1);
    plan_command(CONV_SEXT2, EW16, 8, 1'b1);
    plan_command(CONV_ZEXT2, EW16, 8, 1'b0);
    run_plan();
    end_test("widen by 2");

    // vl 6 leaves the last word partly used
    plan_command(CONV_SEXT4, EW8, 6, 1'b0);
    plan_command(CONV_ZEXT4, EW8, 10, 1'b1);
    plan_command(CONV_SEXT4, EW8, 8, 1'b0);
    run_plan();
    end_test("widen by 4");

    plan_command(CONV_FPWIDE2, EW16, 12, 1'b1);
    run_plan();
    end_test("fp16 to fp32");

    plan_command(CONV_SEXT2, EW16, 6, 1'b0);
    plan_command(CONV_NONE, EW8, 16, 1'b1);
    plan_command(CONV_ZEXT4, EW8, 8, 1'b0);
    plan_command(CONV_FPWIDE2, EW16, 8, 1'b1);
    plan_command(CONV_SEXT4, EW8, 4, 1'b1);
    plan_command(CONV_NONE, EW64, 3, 1'b0);
    ready_mode <= READY_RANDOM;
    run_plan();
    ready_mode <= READY_ALWAYS;
    @(posedge clk);
    end_test("random back-pressure");

    // Fill every credit with the output held
    ready_mode <= READY_HOLD;
    repeat (2) @(posedge clk);
    plan_command(CONV_NONE, EW64, `OPQ_DEPTH, 1'b1);
    fork
      feed_commands();
      feed_words();
    join
    assert (!operand_ready) else begin
      $display("ERROR %0t: operand ready still high with all credits used", $time);
      errors++;
    end
    // Exactly one cycle of output ready
    ready_mode <= READY_ALWAYS;
    @(posedge clk);
    ready_mode <= READY_HOLD;
    cycles = 0;
    while (!operand_ready && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!operand_ready) report_timeout("a credit to return");
    assert (exp_q.size() == `OPQ_DEPTH - 1) else begin
      $display("ERROR %0t: %0d outputs pending after one pop, expected %0d",
               $time, exp_q.size(), `OPQ_DEPTH - 1);
      errors++;
    end
    ready_mode <= READY_ALWAYS;
    wait_drained();
    end_test("credit limit");

    repeat (4) @(posedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/opq_pkg.sv
design/opq_fifo.sv
design/opq_credit_counter.sv
design/opq_convert.sv
design/opq_sequencer.sv
design/operand_queue.sv
bench/operand_queue_sva.sv
bench/operand_queue_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module operand_queue_tb -f files.f

output=$(./obj_dir/Voperand_queue_tb 2>&1) || true
echo "$output"

if grep -qx "Regression passed" <<< "$output"; then
  exit 0
fi
exit 1
